// File: build.f
hw/ula_pkg.sv
hw/video_timing.sv
hw/screen_fetch.sv
hw/video_out.sv
hw/port_fe.sv
hw/int_gen.sv
hw/ula_top.sv
test/tb_ula.sv

// File: hw/int_gen.sv
`default_nettype none

module int_gen
	import ula_pkg::*;
(
	input wire clk28,
	input wire rst_n0,
	input wire timing_mode_e timing_mode,
	input wire beam_t beam,
	output logic n_int
);

	frame_geom_t geom;
	logic int_hit;
	logic pending;
	logic [4:0] cnt;	// cpu clocks since the falling edge

	assign geom = frame_geometry(timing_mode);
	assign int_hit = (beam.vc == geom.int_line) && (beam.hsub[10:2] == geom.int_col);

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			pending <= 1'b0;
			cnt <= '0;
			n_int <= 1'b1;
		end
		else begin
			if (int_hit && n_int && !pending)
				pending <= 1'b1;
			if (beam.cpu_strobe) begin
				if (pending) begin
					n_int <= 1'b0;
					pending <= 1'b0;
					cnt <= '0;
				end
				else if (!n_int) begin
					cnt <= cnt + 5'd1;
					if (cnt == 5'd31)
						n_int <= 1'b1;	// 32 cpu clocks low
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/port_fe.sv
`default_nettype none

module port_fe
	import ula_pkg::*;
(
	input wire clk28,
	input wire rst_n0,
	input wire cpu_bus_t cpu,
	input wire byte_t cpu_din,
	input wire beam_t beam,
	input wire [4:0] kd,
	input wire tape_in,
	output byte_t cpu_dout,
	output logic cpu_doe,
	output color3_t border,
	output logic beeper,
	output logic tape_out
);

	logic port_cs;
	logic [4:0] kd_q;

	// any even port address, not during interrupt acknowledge
	assign port_cs = !cpu.n_iorq && cpu.n_m1 && !cpu.xa[0];

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			border <= '0;
			beeper <= 1'b0;
			tape_out <= 1'b0;
		end
		else if (port_cs && !cpu.n_wr && beam.cpu_strobe) begin	// in step with the cpu clock
			border <= cpu_din[2:0];
			tape_out <= cpu_din[3];
			beeper <= cpu_din[4];
		end
	end

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			kd_q <= 5'b11111;	// no key pressed
			cpu_doe <= 1'b0;
		end
		else begin
			kd_q <= kd;
			cpu_doe <= port_cs && !cpu.n_rd;
		end
	end

	always_ff @(posedge clk28)
		cpu_dout <= {1'b1, tape_in, 1'b1, kd_q};

endmodule

`default_nettype wire

// File: hw/screen_fetch.sv
`default_nettype none

module screen_fetch
	import ula_pkg::*;
#(
	parameter int SCREEN_DELAY = 8
) (
	input wire clk28,
	input wire rst_n0,
	input wire beam_t beam,
	input wire byte_t vd,
	output vram_addr_t va,
	output logic n_vrd,
	output byte_t attr,
	output logic pixel,
	output logic in_screen
);

	localparam hsub_t SHOW_START = hsub_t'(SCREEN_DELAY * 4);
	localparam hsub_t SHOW_END   = hsub_t'((H_AREA + SCREEN_DELAY) * 4);

	hcount_t hc;
	hsub_t ds;
	logic load;
	logic fetch;
	logic show;
	logic cell_load;
	fetch_step_e step;
	fetch_step_e step_q;
	vram_addr_t bitmap_addr;
	vram_addr_t attr_addr;
	byte_t bitmap_next;
	byte_t attr_next;
	byte_t shifter;

	assign hc = beam.hsub[10:2];
	assign ds = beam.hsub - SHOW_START;	// tick within the delayed window

	assign load  = (beam.vc < V_AREA) && (hc < H_AREA);
	assign fetch = load && (beam.hsub[4:3] == 2'b00);	// first two steps of a cell
	assign step  = beam.hsub[2] ? STEP_ATTR : STEP_BITMAP;

	assign show = (beam.vc < V_AREA) && (beam.hsub >= SHOW_START) &&
		(beam.hsub < SHOW_END);
	assign cell_load = show && (ds[4:0] == 5'd0);

	// bitmap rows are interleaved in thirds of the screen
	assign bitmap_addr = {beam.vc[7:6], beam.vc[2:0], beam.vc[5:3], hc[7:3]};
	assign attr_addr   = {3'b110, beam.vc[7:3], hc[7:3]};	// from 6144

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			n_vrd <= 1'b1;
			step_q <= STEP_BITMAP;
			in_screen <= 1'b0;
		end
		else begin
			n_vrd <= !fetch;
			step_q <= step;
			in_screen <= show;
		end
	end

	always_ff @(posedge clk28) begin
		if (fetch)
			va <= (step == STEP_ATTR) ? attr_addr : bitmap_addr;

		// vram answers while n_vrd is low
		if (!n_vrd && step_q == STEP_BITMAP)
			bitmap_next <= vd;
		if (!n_vrd && step_q == STEP_ATTR)
			attr_next <= vd;

		if (cell_load) begin
			shifter <= bitmap_next;
			attr <= attr_next;
		end
		else if (ds[1:0] == 2'b00) begin
			shifter <= {shifter[6:0], 1'b0};	// next pixel
		end
	end

	assign pixel = shifter[7];

endmodule

`default_nettype wire

// File: hw/ula_pkg.sv
`default_nettype none

package ula_pkg;

	typedef logic [8:0]  hcount_t;
	typedef logic [10:0] hsub_t;	// four ticks per pixel
	typedef logic [8:0]  vcount_t;
	typedef logic [7:0]  byte_t;
	typedef logic [12:0] vram_addr_t;
	typedef logic [2:0]  color3_t;	// g r b

	typedef enum logic [1:0] {
		TIMING_PENT = 2'b00,
		TIMING_S128 = 2'b01,
		TIMING_S48  = 2'b11
	} timing_mode_e;

	typedef enum logic {
		STEP_BITMAP,
		STEP_ATTR
	} fetch_step_e;

	localparam int H_AREA = 256;
	localparam int V_AREA = 192;
	localparam vcount_t V_SYNC = 9'd8;	// vsync length in lines

	typedef struct packed {
		hcount_t h_total;
		hcount_t hsync_start;
		hcount_t hsync_width;
		hcount_t blank_start;
		hcount_t blank_width;
		vcount_t v_total;
		vcount_t vsync_start;
		vcount_t int_line;
		hcount_t int_col;
	} frame_geom_t;

	typedef struct packed {
		logic [15:0] xa;
		logic n_rd;
		logic n_wr;
		logic n_iorq;
		logic n_m1;
	} cpu_bus_t;

	typedef struct packed {
		hsub_t hsub;
		vcount_t vc;
		logic blank;
		logic hsync;
		logic vsync;
		logic cpu_strobe;
		logic frame_start;
	} beam_t;

	typedef struct packed {
		logic [1:0] g;
		logic [1:0] r;
		logic [1:0] b;
	} rgb_t;

	// blank starts at the end of the right border, which moves with the display delay
	function automatic frame_geom_t frame_geometry(input timing_mode_e mode,
			input int unsigned delay = 8);
		frame_geom_t g;
		case (mode)
			TIMING_PENT: begin
				g.h_total     = 9'd448;
				g.hsync_start = 9'd329;
				g.blank_start = hcount_t'(H_AREA + 53 + delay);
				g.blank_width = 9'd85;
				g.v_total     = 9'd320;
				g.vsync_start = 9'd248;
				g.int_line    = 9'd239;
				g.int_col     = 9'd316;
			end
			TIMING_S128: begin
				g.h_total     = 9'd456;
				g.hsync_start = 9'd385;
				g.blank_start = hcount_t'(H_AREA + 48 + delay);
				g.blank_width = 9'd104;
				g.v_total     = 9'd311;
				g.vsync_start = 9'd247;
				g.int_line    = 9'd247;
				g.int_col     = 9'd450;
			end
			default: begin	// 48k
				g.h_total     = 9'd448;
				g.hsync_start = 9'd377;
				g.blank_start = hcount_t'(H_AREA + 48 + delay);
				g.blank_width = 9'd96;
				g.v_total     = 9'd312;
				g.vsync_start = 9'd248;
				g.int_line    = 9'd247;
				g.int_col     = 9'd442;
			end
		endcase
		g.hsync_width = 9'd33;
		return g;
	endfunction

endpackage

`default_nettype wire

// File: hw/ula_top.sv
`default_nettype none

module ula_top
	import ula_pkg::*;
#(
	parameter int SCREEN_DELAY = 8
) (
	input wire clk28,
	input wire rst_n0,
	input wire timing_mode_e timing_mode,	// strapped, static

	input wire cpu_bus_t cpu,
	input wire byte_t cpu_din,
	output byte_t cpu_dout,
	output logic cpu_doe,

	input wire [4:0] kd,
	input wire tape_in,

	input wire byte_t vd,
	output vram_addr_t va,
	output logic n_vrd,

	output rgb_t rgb,
	output logic csync,
	output logic hsync,
	output logic vsync,

	output logic clkcpu,
	output logic n_int,
	output logic beeper,
	output logic tape_out
);

	beam_t beam;
	byte_t attr;
	logic pixel;
	logic in_screen;
	color3_t border;

	video_timing #(.SCREEN_DELAY(SCREEN_DELAY)) u_timing (
		.clk28       (clk28),
		.rst_n0      (rst_n0),
		.timing_mode (timing_mode),
		.beam        (beam),
		.clkcpu      (clkcpu)
	);

	screen_fetch #(.SCREEN_DELAY(SCREEN_DELAY)) u_fetch (
		.clk28     (clk28),
		.rst_n0    (rst_n0),
		.beam      (beam),
		.vd        (vd),
		.va        (va),
		.n_vrd     (n_vrd),
		.attr      (attr),
		.pixel     (pixel),
		.in_screen (in_screen)
	);

	video_out u_out (
		.clk28     (clk28),
		.rst_n0    (rst_n0),
		.beam      (beam),
		.attr      (attr),
		.pixel     (pixel),
		.in_screen (in_screen),
		.border    (border),
		.rgb       (rgb),
		.csync     (csync),
		.hsync     (hsync),
		.vsync     (vsync)
	);

	port_fe u_port_fe (
		.clk28    (clk28),
		.rst_n0   (rst_n0),
		.cpu      (cpu),
		.cpu_din  (cpu_din),
		.beam     (beam),
		.kd       (kd),
		.tape_in  (tape_in),
		.cpu_dout (cpu_dout),
		.cpu_doe  (cpu_doe),
		.border   (border),
		.beeper   (beeper),
		.tape_out (tape_out)
	);

	int_gen u_int (
		.clk28       (clk28),
		.rst_n0      (rst_n0),
		.timing_mode (timing_mode),
		.beam        (beam),
		.n_int       (n_int)
	);

endmodule

`default_nettype wire

// File: hw/video_out.sv
`default_nettype none

module video_out
	import ula_pkg::*;
(
	input wire clk28,
	input wire rst_n0,
	input wire beam_t beam,
	input wire byte_t attr,
	input wire pixel,
	input wire in_screen,
	input wire color3_t border,
	output rgb_t rgb,
	output logic csync,
	output logic hsync,
	output logic vsync
);

	color3_t screen_color;

	// bright lifts the low bit of every lit channel
	function automatic rgb_t color_levels(input color3_t c, input logic bright);
		rgb_t o;
		o.g = {c[2], c[2] & bright};
		o.r = {c[1], c[1] & bright};
		o.b = {c[0], c[0] & bright};
		return o;
	endfunction

	assign screen_color = pixel ? attr[2:0] : attr[5:3];	// ink : paper

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			rgb <= '0;
			csync <= 1'b1;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else begin
			if (beam.blank)
				rgb <= '0;
			else if (in_screen)
				rgb <= color_levels(screen_color, attr[6]);
			else
				rgb <= color_levels(border, 1'b0);
			csync <= ~(beam.hsync ^ beam.vsync);
			hsync <= beam.hsync;
			vsync <= beam.vsync;
		end
	end

endmodule

`default_nettype wire

// File: hw/video_timing.sv
`default_nettype none

module video_timing
	import ula_pkg::*;
#(
	parameter int SCREEN_DELAY = 8
) (
	input wire clk28,
	input wire rst_n0,
	input wire timing_mode_e timing_mode,
	output beam_t beam,
	output logic clkcpu
);

	frame_geom_t geom;
	hsub_t hsub;
	vcount_t vc;
	hcount_t hc;
	logic line_end;
	logic frame_end;
	logic hsync_w;
	logic vsync_w;
	logic hblank_w;

	assign geom = frame_geometry(timing_mode, SCREEN_DELAY);
	assign hc = hsub[10:2];	// pixel column

	assign line_end  = hsub == {geom.h_total - 9'd1, 2'b11};
	assign frame_end = vc == geom.v_total - 9'd1;

	always_ff @(posedge clk28 or negedge rst_n0) begin
		if (!rst_n0) begin
			hsub <= '0;
			vc <= '0;
		end
		else if (line_end) begin
			hsub <= '0;
			if (frame_end)
				vc <= '0;
			else
				vc <= vc + 9'd1;
		end
		else begin
			hsub <= hsub + 11'd1;
		end
	end

	assign hsync_w = (hc >= geom.hsync_start) &&
		(hc < geom.hsync_start + geom.hsync_width);
	assign vsync_w = (vc >= geom.vsync_start) &&
		(vc < geom.vsync_start + V_SYNC);
	assign hblank_w = (hc >= geom.blank_start) &&
		(hc < geom.blank_start + geom.blank_width);

	// cpu clock is hsub bit 2, period 8 ticks
	assign clkcpu = hsub[2];

	always_comb begin
		beam.hsub = hsub;
		beam.vc = vc;
		beam.blank = hblank_w || vsync_w;	// vsync lines are blanked too
		beam.hsync = hsync_w;
		beam.vsync = vsync_w;
		beam.cpu_strobe = hsub[2:0] == 3'b100;	// first tick of clkcpu high
		beam.frame_start = (hsub == '0) && (vc == '0);
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ula -f build.f \
	&& ./obj_dir/Vtb_ula > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "Test failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "RESULT: FAIL (no result)"; exit 1; }
echo "RESULT: PASS"

// File: test/tb_ula.sv
`default_nettype none

module tb_ula
	import ula_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic clk28;
	logic rst_n0;
	timing_mode_e timing_mode;
	cpu_bus_t cpu;
	byte_t cpu_din;
	byte_t cpu_dout;
	logic cpu_doe;
	logic [4:0] kd;
	logic tape_in;
	byte_t vd;
	vram_addr_t va;
	logic n_vrd;
	rgb_t rgb;
	logic csync;
	logic hsync;
	logic vsync;
	logic clkcpu;
	logic n_int;
	logic beeper;
	logic tape_out;
	logic read_sel;
	logic [31:0] rng_state;

	ula_top #(.SCREEN_DELAY(8)) dut (.*);

	assign vd = (va < 13'd6144) ? 8'hFF : 8'h0A;	// all ink, red on blue
	assign read_sel = !cpu.n_iorq && cpu.n_m1 && !cpu.xa[0] && !cpu.n_rd;

	initial begin
		clk28 = 1'b0;
		forever #10 clk28 = ~clk28;
	end

	assert property (@(posedge clk28) disable iff (!rst_n0) csync == ~(hsync ^ vsync))
		else report_error("csync is not the inverse of hsync xor vsync");
	assert property (@(posedge clk28) disable iff (!rst_n0) !n_vrd |-> va < 13'd6912)
		else report_error("video read outside the screen memory");
	assert property (@(posedge clk28) disable iff (!rst_n0) cpu_doe |-> $past(read_sel))
		else report_error("cpu_doe high without a port read");

	function automatic int line_total(input timing_mode_e m);
		return (m == TIMING_S128) ? 456 : 448;
	endfunction

	function automatic int sync_start(input timing_mode_e m);
		return (m == TIMING_PENT) ? 329 : (m == TIMING_S128) ? 385 : 377;
	endfunction

	function automatic int frame_total(input timing_mode_e m);
		return (m == TIMING_PENT) ? 320 : (m == TIMING_S128) ? 311 : 312;
	endfunction

	function automatic int vsync_line(input timing_mode_e m);
		return (m == TIMING_S128) ? 247 : 248;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_error(input string msg);
		abort_run($sformatf("CHECK FAILED at %0d ns: %s", $time, msg));
	endtask

	task automatic tick();
		@(posedge clk28);
		#2;
	endtask

	task automatic apply_reset(input timing_mode_e m);
		rst_n0 = 1'b0;
		timing_mode = m;
		repeat (3) tick();
		rst_n0 = 1'b1;
		tick();
		assert (n_int) else report_error("n_int low after reset");
	endtask

	task automatic port_write(input byte_t val);
		cpu.xa = {rng_state[15:8], 8'hFE};
		cpu_din = val;
		cpu.n_iorq = 1'b0;
		cpu.n_wr = 1'b0;
		repeat (10) tick();	// covers a cpu clock strobe
		cpu.n_iorq = 1'b1;
		cpu.n_wr = 1'b1;
		tick();
	endtask

	task automatic port_read_check();
		int waited;
		rng_state = xorshift32(rng_state);
		kd = rng_state[4:0];
		tape_in = rng_state[5];
		repeat (3) tick();
		cpu.xa = 16'h7FFE;
		cpu.n_iorq = 1'b0;
		cpu.n_rd = 1'b0;
		waited = 0;
		while (!cpu_doe && waited < 2) begin
			tick();
			waited++;
		end
		if (!cpu_doe)
			abort_run("timeout: cpu_doe did not rise within 2 cycles of a port read");
		assert (cpu_dout == {1'b1, tape_in, 1'b1, kd})
			else report_error($sformatf("port read gave %h", cpu_dout));
		cpu.n_iorq = 1'b1;
		cpu.n_rd = 1'b1;
		tick();
	endtask

	task automatic wait_vsync_fall(input int limit);
		int n;
		logic vs_q;
		n = 0;
		vs_q = vsync;
		while (!(vs_q && !vsync)) begin
			if (n == limit)
				abort_run("timeout: no end of vsync seen");
			vs_q = vsync;
			tick();
			n++;
		end
	endtask

	// one frame from vsync fall to the next vsync fall
	task automatic check_frame(input timing_mode_e m, input byte_t bd);
		int lt;
		int first_line;
		int since_hs;
		int since_vs;
		int since_int;
		int since_clk;
		int hs_rises;
		int vs_lines;
		int int_falls;
		int clk_rises;
		logic hs_q;
		logic vs_q;
		logic int_q;
		logic clk_q;
		logic done;
		lt = line_total(m);
		first_line = frame_total(m) - vsync_line(m) - 8;
		since_hs = 0;
		since_vs = 0;
		since_int = -1;
		since_clk = 0;
		hs_rises = 0;
		vs_lines = 0;
		int_falls = 0;
		clk_rises = 0;
		hs_q = hsync;
		vs_q = vsync;
		int_q = n_int;
		clk_q = clkcpu;
		done = 1'b0;
		while (!done) begin
			tick();
			since_hs++;
			since_vs++;
			since_int++;
			since_clk++;
			if (since_vs > lt * 4 * (frame_total(m) + 1))
				abort_run("timeout: frame did not end with vsync");
			if (clkcpu && !clk_q) begin
				assert (clk_rises == 0 || since_clk == 8)
					else report_error($sformatf("clkcpu period %0d cycles", since_clk));
				since_clk = 0;
				clk_rises++;
			end
			if (!clkcpu && clk_q && clk_rises > 0) begin
				assert (since_clk == 4)
					else report_error($sformatf("clkcpu high %0d cycles", since_clk));
			end
			if (hsync && !hs_q) begin
				assert (hs_rises == 0 || since_hs == lt * 4)
					else report_error($sformatf("hsync period %0d cycles", since_hs));
				since_hs = 0;
				hs_rises++;
				if (vsync)
					vs_lines++;
			end
			if (!hsync && hs_q && hs_rises > 0) begin
				assert (since_hs == 132)
					else report_error($sformatf("hsync high %0d cycles", since_hs));
			end
			if (!n_int && int_q) begin
				int_falls++;
				since_int = 0;
			end
			if (n_int && !int_q && int_falls > 0) begin
				assert (since_int >= 248 && since_int <= 264)
					else report_error($sformatf("n_int low %0d cycles", since_int));
			end
			// column 128 of the next line
			if (since_hs == (lt - sync_start(m) + 128) * 4 && hs_rises >= first_line &&
					hs_rises < first_line + V_AREA) begin
				assert (rgb == 6'b00_10_00)
					else report_error($sformatf("screen pixel rgb %b", rgb));
			end
			if (since_vs == 288 * 4) begin	// middle of the right border in the line after vsync
				assert (rgb == {bd[2], 1'b0, bd[1], 1'b0, bd[0], 1'b0})
					else report_error($sformatf("border rgb %b for %h", rgb, bd));
				assert (beeper == bd[4] && tape_out == bd[3])
					else report_error("beeper or tape_out does not follow port write");
			end
			done = vs_q && !vsync;
			hs_q = hsync;
			vs_q = vsync;
			int_q = n_int;
			clk_q = clkcpu;
		end
		assert (hs_rises == frame_total(m))
			else report_error($sformatf("frame of %0d lines", hs_rises));
		assert (vs_lines == 8)
			else report_error($sformatf("vsync for %0d lines", vs_lines));
		assert (int_falls == 1)
			else report_error($sformatf("%0d interrupts in a frame", int_falls));
	endtask

	initial begin
		timing_mode_e modes[3];
		byte_t bd;
		modes = '{TIMING_S48, TIMING_S128, TIMING_PENT};
		rst_n0 = 1'b0;
		timing_mode = TIMING_S48;
		cpu = '{xa: 16'hFFFF, n_rd: 1'b1, n_wr: 1'b1, n_iorq: 1'b1, n_m1: 1'b1};
		cpu_din = '0;
		kd = 5'h1F;
		tape_in = 1'b0;
		rng_state = 32'h5409_f014;
		foreach (modes[i]) begin
			apply_reset(modes[i]);
			rng_state = xorshift32(rng_state);
			bd = rng_state[7:0];
			port_write(bd);
			wait_vsync_fall(line_total(modes[i]) * 4 * (frame_total(modes[i]) + 1));
			check_frame(modes[i], bd);
			port_read_check();
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
